//--- aether_macros.svh
`ifndef AETHER_MACROS_SVH
`define AETHER_MACROS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Signed sample width, weights and activations
`define AETHER_DATA_W 8
// Host word width on param_2 and data_o
`define AETHER_WORD_W 16

// ----------------------------------------
// Kernel and buffer sizes
// ----------------------------------------

`define AETHER_TAPS 9
// Unpack FIFO depth in host words
`define AETHER_FIFO_DEPTH 4

// Identification register contents
`define AETHER_VERSN 16'h6C00
`define AETHER_HWRID 16'hB2E9

`endif

//--- aether_instr_pkg.sv
`default_nettype none

`include "aether_macros.svh"

package aether_instr_pkg;

  // Host opcodes on instruction_i
  typedef enum logic [3:0]
  {
    NOP  = 4'h0,
    RST  = 4'h1, // Clear the datapath
    LDW  = 4'h2, // Weight word in param_2
    LDA  = 4'h3, // Activation word in param_2
    RREG = 4'h4, // Register select in param_1
    RRES = 4'h5  // Last convolution result
  } opcode_e;

  // Readable registers, carried in param_1
  typedef enum logic [3:0]
  {
    VERSN = 4'h0,
    HWRID = 4'h1,
    STATS = 4'h2
  } reg_addr_e;

  // One host instruction, 24 bits
  typedef struct packed
  {
    opcode_e                   opcode;
    logic [3:0]                param_1;
    logic [`AETHER_WORD_W-1:0] param_2;
  } aether_cmd_t;

endpackage

`default_nettype wire

//--- aether_data_pkg.sv
`default_nettype none

`include "aether_macros.svh"

package aether_data_pkg;

  // Nine 16-bit products need four extra bits
  localparam int AccW = 2 * `AETHER_DATA_W + $clog2(`AETHER_TAPS);

  typedef logic signed [`AETHER_DATA_W-1:0] sample_t;
  typedef logic        [`AETHER_WORD_W-1:0] word_t;
  typedef logic signed [AccW-1:0]           acc_t;
  typedef logic signed [`AETHER_WORD_W-1:0] result_t; // Saturated window sum

  // Host word with its destination
  typedef struct packed
  {
    logic  is_weight;
    word_t word;
  } tagged_word_t;

  // Unpacked byte, same tag as its word
  typedef struct packed
  {
    logic    is_weight;
    sample_t sample;
  } tagged_sample_t;

  typedef struct packed
  {
    logic [7:0] count;        // Completed windows
    logic       kernel_ready; // All nine taps loaded
  } mac_status_t;

endpackage

`default_nettype wire

//--- aether_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "aether_macros.svh"

module aether_cmd_decoder (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  aether_instr_pkg::aether_cmd_t cmd_i,
  input  logic                          full_i,
  output logic                          push_o,
  output aether_data_pkg::tagged_word_t word_o,
  output logic                          clear_o,
  input  aether_data_pkg::mac_status_t  status_i,
  input  aether_data_pkg::result_t      result_i,
  output aether_data_pkg::word_t        data_o
);

  import aether_instr_pkg::*;
  import aether_data_pkg::*;

  logic  is_load;
  logic  overflow_q;
  word_t stats;
  word_t reg_rdata;

  // ----------------------------------------
  // Load path to the unpack FIFO
  // ----------------------------------------

  assign is_load = (cmd_i.opcode == LDW) || (cmd_i.opcode == LDA);
  assign push_o  = is_load && !full_i; // Dropped while buffer is full

  assign word_o.is_weight = (cmd_i.opcode == LDW);
  assign word_o.word      = cmd_i.param_2;

  // ----------------------------------------
  // Register read mux
  // ----------------------------------------

  // Count in 7:0, ready in 8, overflow in 9
  assign stats = {{(`AETHER_WORD_W - 10){1'b0}}, overflow_q, status_i.kernel_ready,
                  status_i.count};

  always_comb
  begin
    case (reg_addr_e'(cmd_i.param_1))
      VERSN:   reg_rdata = `AETHER_VERSN;
      HWRID:   reg_rdata = `AETHER_HWRID;
      STATS:   reg_rdata = stats;
      default: reg_rdata = '0; // Unmapped address
    endcase
  end

  // ----------------------------------------
  // Clear pulse, overflow flag, read data
  // ----------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      clear_o    <= 1'b0;
      overflow_q <= 1'b0;
    end
    else
    begin
      clear_o <= (cmd_i.opcode == RST);

      if (cmd_i.opcode == RST)
        overflow_q <= 1'b0;
      else if (is_load && full_i)
        overflow_q <= 1'b1; // Sticky until RST
    end
  end

  // Holds its value between reads
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      data_o <= '0;
    else if (cmd_i.opcode == RREG)
      data_o <= reg_rdata;
    else if (cmd_i.opcode == RRES)
      data_o <= word_t'(result_i);
  end

  // A load refused by the full buffer shows up in STATS
  a_drop_sets_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (is_load && full_i) |=> overflow_q
  );

endmodule

`default_nettype wire

//--- aether_unpack_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "aether_macros.svh"

module aether_unpack_fifo (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            clear_i,
  input  logic                            push_i,
  input  aether_data_pkg::tagged_word_t   word_i,
  output logic                            full_o,
  output logic                            sample_valid_o,
  output aether_data_pkg::tagged_sample_t sample_o
);

  import aether_data_pkg::*;

  localparam int Depth = `AETHER_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  localparam int CntW  = $clog2(Depth + 1);

  tagged_word_t    mem_q [Depth];
  tagged_word_t    head;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_addr;
  logic [CntW-1:0] count_q;
  logic            half_q; // High byte of head word next
  logic            wr_en;
  logic            word_done;

  assign full_o         = (count_q == CntW'(Depth));
  assign sample_valid_o = (count_q != '0);
  assign wr_en          = push_i && !full_o;
  assign word_done      = sample_valid_o && half_q; // Second byte leaves this cycle

  // A push during clear lands in slot 0
  assign wr_addr = clear_i ? '0 : wr_ptr_q;

  // ----------------------------------------
  // Output byte select, low byte first
  // ----------------------------------------

  assign head               = mem_q[rd_ptr_q];
  assign sample_o.is_weight = head.is_weight;
  assign sample_o.sample    = half_q ? head.word[`AETHER_WORD_W-1:`AETHER_DATA_W]
                                     : head.word[`AETHER_DATA_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem_q[wr_addr] <= word_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      half_q   <= 1'b0;
    end
    else if (clear_i)
    begin
      wr_ptr_q <= wr_en ? PtrW'(1) : '0;
      rd_ptr_q <= '0;
      count_q  <= wr_en ? CntW'(1) : '0;
      half_q   <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (word_done)
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (sample_valid_o)
        half_q <= !half_q;

      case ({wr_en, word_done})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Idle or push and pop together
      endcase
    end
  end

  // Decoder gates its pushes on full
  a_no_write_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    full_o |-> !push_i
  );

  a_occupancy: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntW'(Depth)
  );

endmodule

`default_nettype wire

//--- aether_kernel_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "aether_macros.svh"

module aether_kernel_mac (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            clear_i,
  input  logic                            sample_valid_i,
  input  aether_data_pkg::tagged_sample_t sample_i,
  output aether_data_pkg::mac_status_t    status_o,
  output aether_data_pkg::result_t        result_o
);

  import aether_data_pkg::*;

  localparam int   Taps   = `AETHER_TAPS;
  localparam int   IdxW   = $clog2(Taps);
  localparam acc_t SatMax = acc_t'((1 << (`AETHER_WORD_W - 1)) - 1);
  localparam acc_t SatMin = -SatMax - acc_t'(1);

  typedef enum logic
  {
    KERNEL_EMPTY,
    KERNEL_READY
  } kernel_state_e;

  sample_t         weights_q [Taps];
  kernel_state_e   state_q;
  logic [IdxW-1:0] w_idx_q;   // Next weight tap
  logic [IdxW-1:0] a_idx_q;   // Running activation tap
  logic [7:0]      count_q;
  acc_t            acc_q;
  acc_t            product;
  acc_t            sum;
  result_t         sat_sum;
  logic            load_weight;
  logic            load_act;
  logic            last_tap;

  assign load_weight = sample_valid_i && sample_i.is_weight;
  assign load_act    = sample_valid_i && !sample_i.is_weight && (state_q == KERNEL_READY);
  assign last_tap    = (a_idx_q == IdxW'(Taps - 1));

  // ----------------------------------------
  // Multiply, accumulate, saturate
  // ----------------------------------------

  assign product = acc_t'(sample_i.sample) * acc_t'(weights_q[a_idx_q]);
  assign sum     = acc_q + product;

  always_comb
  begin
    if (sum > SatMax)
      sat_sum = result_t'(SatMax);
    else if (sum < SatMin)
      sat_sum = result_t'(SatMin);
    else
      sat_sum = result_t'(sum);
  end

  assign status_o.count        = count_q;
  assign status_o.kernel_ready = (state_q == KERNEL_READY);

  // Taps fill in arrival order and wrap
  always_ff @(posedge clk_i)
  begin
    if (load_weight)
      weights_q[w_idx_q] <= sample_i.sample;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || clear_i)
    begin
      state_q <= KERNEL_EMPTY;
      w_idx_q <= '0;
      a_idx_q <= '0;
      count_q <= '0;
      acc_q   <= '0;
    end
    else
    begin
      if (load_weight)
      begin
        w_idx_q <= (w_idx_q == IdxW'(Taps - 1)) ? '0 : w_idx_q + 1'b1;
        if (w_idx_q == IdxW'(Taps - 1))
          state_q <= KERNEL_READY; // Ninth weight in
      end

      if (load_act)
      begin
        if (last_tap)
        begin
          a_idx_q <= '0;
          acc_q   <= '0;
          count_q <= count_q + 1'b1;
        end
        else
        begin
          a_idx_q <= a_idx_q + 1'b1;
          acc_q   <= sum;
        end
      end
    end
  end

  // Result survives a clear
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      result_o <= '0;
    else if (load_act && last_tap)
      result_o <= sat_sum;
  end

  a_tap_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (a_idx_q < IdxW'(Taps)) && (w_idx_q < IdxW'(Taps))
  );

endmodule

`default_nettype wire

//--- aether_engine.sv
`timescale 1ns/1ps
`default_nettype none

module aether_engine (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [3:0]  instruction_i, // Opcode
  input  logic [3:0]  param_1_i,     // Register select
  input  logic [15:0] param_2_i,     // Load data
  output logic [15:0] data_o,        // Read data
  output logic        interrupt_o    // Buffer full, host must wait
);

  import aether_instr_pkg::*;
  import aether_data_pkg::*;

  aether_cmd_t    cmd;
  tagged_word_t   push_word;
  tagged_sample_t sample;
  mac_status_t    mac_status;
  result_t        mac_result;
  logic           push;
  logic           full;
  logic           clear;
  logic           sample_valid;

  // ----------------------------------------
  // Host instruction bus
  // ----------------------------------------

  assign cmd.opcode  = opcode_e'(instruction_i);
  assign cmd.param_1 = param_1_i;
  assign cmd.param_2 = param_2_i;

  assign interrupt_o = full;

  aether_cmd_decoder decoder_inst (
    .clk_i, .rst_n_i, .cmd_i(cmd), .full_i(full), .push_o(push), .word_o(push_word),
    .clear_o(clear), .status_i(mac_status), .result_i(mac_result), .data_o
  );

  aether_unpack_fifo fifo_inst (
    .clk_i, .rst_n_i, .clear_i(clear), .push_i(push), .word_i(push_word),
    .full_o(full), .sample_valid_o(sample_valid), .sample_o(sample)
  );

  aether_kernel_mac mac_inst (
    .clk_i, .rst_n_i, .clear_i(clear), .sample_valid_i(sample_valid), .sample_i(sample),
    .status_o(mac_status), .result_o(mac_result)
  );

endmodule

`default_nettype wire

//--- aether_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "aether_macros.svh"

module aether_engine_tb;

  import aether_instr_pkg::*;

  localparam int ClkHalf  = 20;
  localparam int DriveDly = 2; // Inputs change after the rising edge
  localparam string VecFile = "aether_engine_vectors.txt";

  logic        clk;
  logic        rst_n;
  logic [3:0]  instruction;
  logic [3:0]  param_1;
  logic [15:0] param_2;
  logic [15:0] data;
  logic        interrupt;

  // Kernel model state
  logic signed [7:0] model_w [`AETHER_TAPS];
  int                w_idx;
  int                a_idx;
  int                acc;
  logic              ready;
  logic              model_ovf;
  logic [7:0]        model_count;
  logic [15:0]       model_result;

  logic [31:0] rand_state;
  logic        seen_full; // interrupt_o observed during a burst
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          ops_run;

  aether_engine UUT (
    .clk_i(clk), .rst_n_i(rst_n), .instruction_i(instruction), .param_1_i(param_1),
    .param_2_i(param_2), .data_o(data), .interrupt_o(interrupt)
  );

  initial
  begin
    clk = 1'b0;
    forever #ClkHalf clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit)
      abort_run($sformatf("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt));
  end

  task automatic abort_run(input string reason);
  begin
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  end
  endtask

  task automatic check_equal(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
  begin
    assert (actual === expected)
    else
      abort_run($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
  end
  endtask

  // ----------------------------------------
  // Host bus driving
  // ----------------------------------------

  task automatic issue(input logic [3:0] op, input logic [3:0] p1, input logic [15:0] p2);
  begin
    instruction = op;
    param_1     = p1;
    param_2     = p2;
    @(posedge clk);
    #DriveDly;
    instruction = NOP; // Bus idles unless the next call drives it
    param_1     = '0;
    param_2     = '0;
  end
  endtask

  task automatic idle(input int cycles);
  begin
    repeat (cycles)
    begin
      @(posedge clk);
      #DriveDly;
    end
  end
  endtask

  // ----------------------------------------
  // Reference MAC model
  // ----------------------------------------

  function automatic logic [15:0] saturate(input int sum);
    if (sum > 32767)
      return 16'h7FFF;
    else if (sum < -32768)
      return 16'h8000;
    return sum[15:0];
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic model_clear();
  begin
    w_idx       = 0;
    a_idx       = 0;
    acc         = 0;
    ready       = 1'b0;
    model_ovf   = 1'b0;
    model_count = '0;
  end
  endtask

  task automatic apply_sample(input logic is_weight, input logic signed [7:0] s);
  begin
    if (is_weight)
    begin
      model_w[w_idx] = s;
      if (w_idx == `AETHER_TAPS - 1)
        ready = 1'b1;
      w_idx = (w_idx + 1) % `AETHER_TAPS; // Tenth weight wraps to tap 0
    end
    else if (ready)
    begin
      acc = acc + int'(s) * int'(model_w[a_idx]);
      if (a_idx == `AETHER_TAPS - 1)
      begin
        model_result = saturate(acc);
        model_count  = model_count + 1'b1;
        acc          = 0;
        a_idx        = 0;
      end
      else
        a_idx = a_idx + 1;
    end
  end
  endtask

  task automatic send_load(input logic is_weight, input logic [15:0] word, input logic obey);
    logic dropped;
  begin
    while (obey && interrupt)
    begin
      seen_full = 1'b1;
      idle(1);
    end
    dropped = interrupt; // Full only changes at an edge
    if (dropped)
      seen_full = 1'b1;
    issue(is_weight ? LDW : LDA, 4'h0, word);
    if (dropped)
      model_ovf = 1'b1;
    else
    begin
      apply_sample(is_weight, word[7:0]); // Low byte first
      apply_sample(is_weight, word[15:8]);
    end
  end
  endtask

  // Poll STATS until the window count reaches the model
  task automatic sync_count();
    logic matched;
  begin
    matched = 1'b0;
    while (!matched)
    begin
      issue(RREG, STATS, 16'h0);
      matched = (data[7:0] == model_count);
    end
  end
  endtask

  task automatic run_burst(input int words, input logic obey, input string missing);
  begin
    seen_full = 1'b0;
    repeat (words)
    begin
      rand_state = lcg_next(rand_state);
      send_load(1'b0, rand_state[23:8], obey);
    end
    assert (seen_full)
    else
      abort_run(missing);
  end
  endtask

  // Next operation letter and value, comment lines skipped
  task automatic next_op(input int fd, output logic [7:0] op, output logic [19:0] value,
                         output logic found);
    logic [8*128-1:0] skip;
    int               n;
  begin
    found = 1'b0;
    n = $fscanf(fd, " %c", op);
    while (n == 1 && op == "#")
    begin
      n = $fgets(skip, fd);
      n = $fscanf(fd, " %c", op);
    end
    if (n == 1)
      found = ($fscanf(fd, " %h", value) == 1);
  end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial
  begin
    int          fd;
    int          lines;
    logic [7:0]  op;
    logic [19:0] value;
    logic        found;
    string       name;

    rst_n       = 1'b0;
    instruction = NOP;
    param_1     = '0;
    param_2     = '0;
    model_clear();
    model_result = '0;
    rand_state   = 32'h85b2;
    seen_full    = 1'b0;
    ops_run      = 0;
    lines        = 0;

    fd = $fopen(VecFile, "r");
    if (fd == 0)
      abort_run("Cannot open the vector file aether_engine_vectors.txt");
    next_op(fd, op, value, found);
    while (found)
    begin
      lines = lines + 1;
      next_op(fd, op, value, found);
    end
    $fclose(fd);
    cycle_limit = 40 * lines + 500;

    repeat (10) @(posedge clk);
    #DriveDly;
    rst_n = 1'b1;
    check_equal("reset data_o", 16'h0000, data);
    assert (!interrupt)
    else
      abort_run("interrupt_o is high right after reset");

    fd = $fopen(VecFile, "r");
    next_op(fd, op, value, found);
    while (found)
    begin
      ops_run = ops_run + 1;
      name    = $sformatf("%c op %0d", op, ops_run);
      case (op)
        "R":
        begin
          issue(RST, 4'h0, 16'h0);
          idle(1); // Clear pulse lands
          model_clear();
        end
        "W": send_load(1'b1, value[15:0], 1'b1);
        "A": send_load(1'b0, value[15:0], 1'b1);
        "E":
        begin
          check_equal({name, " model"}, value[15:0], model_result);
          sync_count();
          issue(RRES, 4'h0, 16'h0);
          check_equal(name, value[15:0], data);
        end
        "G":
        begin
          idle(10); // Buffer drains, at most eight samples
          issue(RREG, value[19:16], 16'h0);
          check_equal(name, value[15:0], data);
        end
        "B":
        begin
          run_burst(int'(value), 1'b1, "interrupt_o never rose during the activation burst");
          sync_count();
          check_equal({name, " stats"}, {6'b0, model_ovf, ready, model_count}, data);
          issue(RRES, 4'h0, 16'h0);
          check_equal({name, " result"}, model_result, data);
        end
        "O": run_burst(int'(value), 1'b0, "No load was sent while interrupt_o was high");
        default: abort_run($sformatf("Unknown operation %c in the vector file", op));
      endcase
      next_op(fd, op, value, found);
    end
    $fclose(fd);

    if (ops_run > 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
      abort_run("The vector file held no operations");
  end

endmodule

`default_nettype wire

//--- aether_engine_vectors.txt
# op value: R clear, W weight word, A activation word, E expected result
# G reg nibble then expected word, B random burst words, O loads ignoring full
G 06C00
G 1B2E9
G 20000
W 0201
W 0403
W 0605
W 0807
W FF09
G 20100
A 0101
A 0101
A 0101
A 0101
A 0201
E 002B
B 0010
B 0013
R 0000
W 7F7F
W 7F7F
W 7F7F
W 7F7F
W 7F7F
A 7F7F
A 7F7F
A 7F7F
A 7F7F
A 807F
E 7FFF
A 8080
A 8080
A 8080
A 8080
E 8000
R 0000
G 20000
A 1234
A 1234
G 20000
E 8000
O 000C
G 20200
R 0000
G 20000

//--- aether_engine.f
+incdir+.
aether_instr_pkg.sv
aether_data_pkg.sv
aether_cmd_decoder.sv
aether_unpack_fifo.sv
aether_kernel_mac.sv
aether_engine.sv
aether_engine_tb.sv

//--- Bender.yml
package:
  name: aether_engine

export_include_dirs:
  - .

sources:
  - files:
      - aether_instr_pkg.sv
      - aether_data_pkg.sv
      - aether_cmd_decoder.sv
      - aether_unpack_fifo.sv
      - aether_kernel_mac.sv
      - aether_engine.sv
  - target: test
    files:
      - aether_engine_tb.sv
